//--- mem_stage.f
hdl/mem_stage_pkg.sv
hdl/mem_access_decode.sv
hdl/load_store_controller.sv
hdl/writeback_select.sv
hdl/mem_stage.sv
verif/mem_stage_tb_mem.sv
verif/mem_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= mem_stage_tb
RTL_TOP   ?= mem_stage
FLIST     ?= mem_stage.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD) $(LOG)

//--- verif/mem_stage_tb.sv
`timescale 1ns/10ps

module mem_stage_tb;

    import mem_stage_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int RAND_RECORDS = 32;
    // Records per test, in test order
    localparam int N_RECORDS    = 3 + 46 + 6 + 4 + RAND_RECORDS;
    localparam int DRAIN_LIMIT  = 200;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + N_RECORDS * 20 + 500) * CLK_PERIOD;

    logic     CLK;
    logic     rst;
    ex_mem_t  ex_mem;
    axi_req_t axi_req;
    axi_rsp_t axi_rsp;
    logic     mem_stall;
    mem_wb_t  mem_wb;
    logic     halt;

    // Expected results in issue order
    mem_wb_t     exp_q[$];
    // Byte image of the slave memory
    logic [7:0]  shadow [256];
    integer      seed;
    int          errors;
    int          checks;
    int          tests;
    int          stall_cycles;
    int          bus_valid_cycles;

    mem_stage uut (
        .CLK       (CLK),
        .rst       (rst),
        .ex_mem    (ex_mem),
        .axi_rsp   (axi_rsp),
        .mem_stall (mem_stall),
        .axi_req   (axi_req),
        .mem_wb    (mem_wb),
        .halt      (halt)
    );

    mem_stage_tb_mem slave (
        .CLK     (CLK),
        .rst     (rst),
        .axi_req (axi_req),
        .axi_rsp (axi_rsp)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // Hard limit on run time
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the tests did not finish in time");
        $display("=== FAIL ===");
        $finish;
    end

    task automatic fail_check(string what);
        $display("Error: %s", what);
        errors++;
    endtask

    task automatic compare_field(string name, word_t got, word_t exp);
        checks++;
        assert (got === exp) else begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic logic in_err_window(word_t a);
        return (a[31:8] == '0) && (a[7:0] >= 8'hc0) && (a[7:0] <= 8'hdf);
    endfunction

    function automatic int access_size(load_type_e lt);
        if (lt == LW) return 4;
        if (lt == LH || lt == LHU) return 2;
        return 1;
    endfunction

    // Reference model built byte by byte from the shadow image
    function automatic mem_wb_t expect_result(ex_mem_t r);
        mem_wb_t m;
        int      size;
        logic    is_mem;
        logic    mal;
        logic    err;
        word_t   ld;
        m      = '0;
        size   = access_size(r.load_type);
        is_mem = r.dren || r.dwen;
        mal    = is_mem && (r.port_out % size != 0);
        err    = is_mem && !mal && in_err_window(r.port_out);
        ld     = '0;
        for (int k = 0; k < size; k++) begin
            ld[8*k +: 8] = shadow[8'(r.port_out + k)];
        end
        if ((r.load_type == LB || r.load_type == LH) && ld[8*size-1]) begin
            ld = ld | (32'hffff_ffff << (8 * size));
        end
        m.valid = 1'b1;
        m.rd    = r.rd;
        if (mal) m.exc = r.dren ? EXC_MAL_L : EXC_MAL_S;
        else if (err) m.exc = r.dren ? EXC_FAULT_L : EXC_FAULT_S;
        else m.exc = EXC_NONE;
        m.reg_write = r.reg_write && (m.exc == EXC_NONE);
        case (r.w_sel)
            W_LOAD:  m.reg_wdata = ld;
            W_PC4:   m.reg_wdata = r.pc4;
            W_IMM_U: m.reg_wdata = r.imm_u;
            default: m.reg_wdata = r.port_out;
        endcase
        m.badaddr = (m.exc != EXC_NONE) ? r.port_out : '0;
        return m;
    endfunction

    function automatic ex_mem_t make_rec(logic rd_op, logic wr_op, load_type_e lt, word_t addr,
                                         word_t rs2, w_sel_e ws, reg_idx_t rd, logic rw);
        ex_mem_t r;
        r           = '0;
        r.valid     = 1'b1;
        r.pc        = 32'h0000_2000 + {addr[11:0], 2'b00};
        r.pc4       = r.pc + 4;
        r.dren      = rd_op;
        r.dwen      = wr_op;
        r.load_type = lt;
        r.rs2_data  = rs2;
        r.port_out  = addr;
        r.imm_u     = {addr[19:0] ^ 20'h5a5a5, 12'h000};
        r.w_sel     = ws;
        r.rd        = rd;
        r.reg_write = rw;
        return r;
    endfunction

    // Model the record, then hold it on ex_mem until the stage takes it
    task automatic issue(ex_mem_t r);
        mem_wb_t e;
        int      size;
        e = expect_result(r);
        if (r.dwen && e.exc == EXC_NONE) begin
            size = access_size(r.load_type);
            for (int k = 0; k < size; k++) begin
                shadow[8'(r.port_out + k)] = r.rs2_data[8*k +: 8];
            end
        end
        exp_q.push_back(e);
        @(negedge CLK);
        ex_mem = r;
        while (mem_stall) @(negedge CLK);
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        @(negedge CLK);
        ex_mem = '0;
        while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
            @(negedge CLK);
            n++;
        end
        assert (exp_q.size() == 0) else
            fail_check($sformatf("timeout waiting for writeback, %0d missing", exp_q.size()));
        exp_q.delete();
    endtask

    task automatic check_result();
        mem_wb_t e;
        assert (exp_q.size() != 0) else fail_check("writeback seen with nothing outstanding");
        if (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            compare_field("mem_wb.rd", word_t'(mem_wb.rd), word_t'(e.rd));
            compare_field("mem_wb.reg_write", word_t'(mem_wb.reg_write), word_t'(e.reg_write));
            compare_field("mem_wb.exc", word_t'(mem_wb.exc), word_t'(e.exc));
            compare_field("mem_wb.badaddr", mem_wb.badaddr, e.badaddr);
            if (e.exc == EXC_NONE) begin
                compare_field("mem_wb.reg_wdata", mem_wb.reg_wdata, e.reg_wdata);
            end
        end
    endtask

    // Outputs sampled mid-cycle where they are stable
    always @(negedge CLK) begin
        if (!rst) begin
            if (mem_stall) stall_cycles++;
            if (axi_req.aw_valid || axi_req.w_valid || axi_req.ar_valid) bus_valid_cycles++;
            if (mem_wb.valid) check_result();
        end
    end

    task automatic report_test(string name, int e0);
        tests++;
        if (errors == e0) $display("%s: ok", name);
        else $display("%s: %0d errors", name, errors - e0);
    endtask

    task automatic test_non_memory();
        int      e0;
        int      s0;
        ex_mem_t r;
        w_sel_e  ws [3];
        e0 = errors;
        s0 = stall_cycles;
        ws = '{W_PC4, W_IMM_U, W_ALU};
        for (int i = 0; i < 3; i++) begin
            r      = make_rec(1'b0, 1'b0, LW, 32'h1234_5670 + i, '0, ws[i], 5'(i + 3), i != 1);
            r.halt = (i == 2);
            issue(r);
            @(negedge CLK);
            ex_mem = '0;
            // One cycle after the accepting edge
            assert (mem_wb.valid && !mem_stall) else fail_check("writeback not one cycle late");
            assert (halt == r.halt) else fail_check("halt output wrong");
        end
        wait_done();
        assert (stall_cycles == s0) else fail_check("stall raised for a non-memory record");
        report_test("non_memory", e0);
    endtask

    task automatic test_load_store();
        int         e0;
        int         size;
        load_type_e lts [5];
        e0  = errors;
        lts = '{LB, LH, LW, LBU, LHU};
        for (int off = 0; off < 4; off++) begin
            issue(make_rec(0, 1, LB, 32'h40 + off, 32'h1111_1100 | (8'h80 + 16 * off),
                           W_ALU, 5'd0, 1'b0));
        end
        issue(make_rec(0, 1, LH, 32'h44, 32'h0000_1234, W_ALU, 5'd0, 1'b0));
        issue(make_rec(0, 1, LH, 32'h46, 32'hffff_8a5c, W_ALU, 5'd0, 1'b0));
        issue(make_rec(0, 1, LW, 32'h48, 32'hcafe_f00d, W_ALU, 5'd0, 1'b0));
        foreach (lts[t]) begin
            size = access_size(lts[t]);
            for (int base = 32'h40; base <= 32'h48; base += 4) begin
                for (int off = 0; off < 4; off += size) begin
                    issue(make_rec(1, 0, lts[t], base + off, '0, W_LOAD, 5'(off + 8 * t), 1));
                end
            end
        end
        wait_done();
        report_test("load_store", e0);
    endtask

    task automatic test_misaligned();
        int e0;
        int b0;
        int s0;
        e0 = errors;
        b0 = bus_valid_cycles;
        s0 = stall_cycles;
        issue(make_rec(1, 0, LH, 32'h21, '0, W_LOAD, 5'd1, 1'b1));
        issue(make_rec(1, 0, LHU, 32'h23, '0, W_LOAD, 5'd2, 1'b1));
        issue(make_rec(1, 0, LW, 32'h22, '0, W_LOAD, 5'd3, 1'b1));
        issue(make_rec(1, 0, LW, 32'h21, '0, W_LOAD, 5'd4, 1'b1));
        issue(make_rec(0, 1, LH, 32'h25, 32'h0000_beef, W_ALU, 5'd0, 1'b0));
        issue(make_rec(0, 1, LW, 32'h27, 32'h7654_3210, W_ALU, 5'd0, 1'b0));
        wait_done();
        assert (bus_valid_cycles == b0) else fail_check("bus request raised for misaligned access");
        assert (stall_cycles == s0) else fail_check("stall raised for a misaligned access");
        report_test("misaligned", e0);
    endtask

    task automatic test_bus_error();
        int e0;
        e0 = errors;
        issue(make_rec(1, 0, LW, 32'hc4, '0, W_LOAD, 5'd5, 1'b1));
        issue(make_rec(1, 0, LBU, 32'hc9, '0, W_LOAD, 5'd6, 1'b1));
        issue(make_rec(0, 1, LW, 32'hd0, 32'h0bad_0bad, W_ALU, 5'd0, 1'b0));
        issue(make_rec(0, 1, LH, 32'hde, 32'h0000_5555, W_ALU, 5'd0, 1'b0));
        wait_done();
        report_test("bus_error", e0);
    endtask

    task automatic test_random_stream();
        int         e0;
        int         size;
        logic       store;
        load_type_e lt;
        word_t      addr;
        e0 = errors;
        for (int i = 0; i < RAND_RECORDS; i++) begin
            store = $random(seed) & 1;
            if (store) lt = load_type_e'($unsigned($random(seed)) % 3);
            else lt = load_type_e'($unsigned($random(seed)) % 5);
            size = access_size(lt);
            addr = word_t'($unsigned($random(seed)) & 8'hff);
            // Aligned addresses that still hit the window now and then
            addr = addr & ~word_t'(size - 1);
            if (store) issue(make_rec(0, 1, lt, addr, $random(seed), W_ALU, 5'd0, 1'b0));
            else issue(make_rec(1, 0, lt, addr, '0, W_LOAD, 5'($random(seed)), 1'b1));
        end
        wait_done();
        report_test("random_stream", e0);
    endtask

    initial begin
        seed             = 32'hfab6_4b38;
        errors           = 0;
        checks           = 0;
        tests            = 0;
        stall_cycles     = 0;
        bus_valid_cycles = 0;
        ex_mem           = '0;
        rst              = 1'b1;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        rst = 1'b0;
        // Start the image from the slave's fill
        for (int i = 0; i < 64; i++) begin
            for (int k = 0; k < 4; k++) begin
                shadow[4 * i + k] = slave.mem[i][8*k +: 8];
            end
        end
        test_non_memory();
        test_load_store();
        test_misaligned();
        test_bus_error();
        test_random_stream();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- verif/mem_stage_tb_mem.sv
`timescale 1ns/10ps

module mem_stage_tb_mem (
    input  logic                    CLK,
    input  logic                    rst,
    input  mem_stage_pkg::axi_req_t axi_req,
    output mem_stage_pkg::axi_rsp_t axi_rsp
);

    import mem_stage_pkg::*;

    // Error window, bytes 0xC0 to 0xDF
    localparam logic [7:0] ERR_LO    = 8'hc0;
    localparam logic [7:0] ERR_HI    = 8'hdf;
    localparam axi_resp_t  RESP_SLVERR = 2'b10;

    word_t  mem [64];
    integer seed;
    int     wait_cnt;
    int     phase;
    logic   is_rd;
    word_t  addr;
    word_t  wdata;
    strb_t  strb;

    function automatic int draw_wait();
        return $unsigned($random(seed)) % 4;
    endfunction

    function automatic logic in_window(word_t a);
        return (a[31:8] == '0) && (a[7:0] >= ERR_LO) && (a[7:0] <= ERR_HI);
    endfunction

    // Fill pattern built from the full word index
    initial begin
        seed = 32'hfab6_4b38;
        for (int i = 0; i < 64; i++) begin
            mem[i] = {8'(i), 8'(~i), 8'(i * 3 + 1), 8'(i ^ 8'h5a)};
        end
    end

    // Phase 0 waits for a request, 1 delays the ready, 2 delays the response
    always @(posedge CLK) begin
        if (rst) begin
            axi_rsp  <= '0;
            phase    <= 0;
            wait_cnt <= 0;
        end else begin
            case (phase)
                0: begin
                    if (axi_req.ar_valid) begin
                        is_rd    <= 1'b1;
                        addr     <= axi_req.ar_addr;
                        wait_cnt <= draw_wait();
                        phase    <= 1;
                    end else if (axi_req.aw_valid && axi_req.w_valid) begin
                        is_rd    <= 1'b0;
                        addr     <= axi_req.aw_addr;
                        wdata    <= axi_req.w_data;
                        strb     <= axi_req.w_strb;
                        wait_cnt <= draw_wait();
                        phase    <= 1;
                    end
                end
                1: begin
                    if (axi_rsp.ar_ready || axi_rsp.aw_ready) begin
                        // Handshake taken this edge
                        axi_rsp.ar_ready <= 1'b0;
                        axi_rsp.aw_ready <= 1'b0;
                        axi_rsp.w_ready  <= 1'b0;
                        if (!is_rd && !in_window(addr)) begin
                            for (int b = 0; b < 4; b++) begin
                                if (strb[b]) begin
                                    mem[addr[7:2]][8*b +: 8] <= wdata[8*b +: 8];
                                end
                            end
                        end
                        wait_cnt <= draw_wait();
                        phase    <= 2;
                    end else if (wait_cnt == 0) begin
                        if (is_rd) begin
                            axi_rsp.ar_ready <= 1'b1;
                        end else begin
                            axi_rsp.aw_ready <= 1'b1;
                            axi_rsp.w_ready  <= 1'b1;
                        end
                    end else begin
                        wait_cnt <= wait_cnt - 1;
                    end
                end
                default: begin
                    if ((axi_rsp.b_valid && axi_req.b_ready) ||
                        (axi_rsp.r_valid && axi_req.r_ready)) begin
                        axi_rsp.b_valid <= 1'b0;
                        axi_rsp.r_valid <= 1'b0;
                        phase           <= 0;
                    end else if (!axi_rsp.b_valid && !axi_rsp.r_valid) begin
                        if (wait_cnt == 0) begin
                            if (is_rd) begin
                                axi_rsp.r_valid <= 1'b1;
                                axi_rsp.r_data  <= mem[addr[7:2]];
                                axi_rsp.r_resp  <= in_window(addr) ? RESP_SLVERR : AXI_RESP_OKAY;
                            end else begin
                                axi_rsp.b_valid <= 1'b1;
                                axi_rsp.b_resp  <= in_window(addr) ? RESP_SLVERR : AXI_RESP_OKAY;
                            end
                        end else begin
                            wait_cnt <= wait_cnt - 1;
                        end
                    end
                end
            endcase
        end
    end

endmodule

//--- hdl/mem_stage.sv
`timescale 1ns/10ps

module mem_stage (
    input  logic                    CLK,
    input  logic                    rst,
    input  mem_stage_pkg::ex_mem_t  ex_mem,
    input  mem_stage_pkg::axi_rsp_t axi_rsp,
    output logic                    mem_stall,
    output mem_stage_pkg::axi_req_t axi_req,
    output mem_stage_pkg::mem_wb_t  mem_wb,
    output logic                    halt
);

    import mem_stage_pkg::*;

    // Held record, drives everything downstream
    ex_mem_t current_instr;
    access_t access;
    word_t   load_word;
    logic    bus_error;

    // Lanes, strobes and alignment of the held record
    mem_access_decode u_decode (
        .instr  (current_instr),
        .access (access)
    );

    // Instruction register and bus FSM
    load_store_controller u_lsc (
        .CLK           (CLK),
        .rst           (rst),
        .ex_mem        (ex_mem),
        .access        (access),
        .axi_rsp       (axi_rsp),
        .current_instr (current_instr),
        .axi_req       (axi_req),
        .mem_stall     (mem_stall),
        .load_word     (load_word),
        .bus_error     (bus_error)
    );

    // Result and exception
    writeback_select u_wb (
        .current_instr (current_instr),
        .misaligned    (access.misaligned),
        .load_word     (load_word),
        .bus_error     (bus_error),
        .mem_stall     (mem_stall),
        .mem_wb        (mem_wb)
    );

    // Bubbles never halt
    assign halt = current_instr.halt && current_instr.valid;

endmodule

//--- hdl/writeback_select.sv
`timescale 1ns/10ps

module writeback_select (
    input  mem_stage_pkg::ex_mem_t current_instr,
    input  logic                   misaligned,
    input  mem_stage_pkg::word_t   load_word,
    input  logic                   bus_error,
    input  logic                   mem_stall,
    output mem_stage_pkg::mem_wb_t mem_wb
);

    import mem_stage_pkg::*;

    logic [1:0]  offset;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    logic        is_mem;
    word_t       load_ext;
    word_t       wdata;
    exc_e        exc;

    assign offset  = current_instr.port_out[1:0];
    // Same lanes the store strobes pick
    assign ld_byte = load_word[{offset, 3'b000} +: 8];
    assign ld_half = offset[1] ? load_word[31:16] : load_word[15:0];
    assign is_mem  = current_instr.dren || current_instr.dwen;

    // Sign or zero extension
    always_comb begin
        case (current_instr.load_type)
            LB:      load_ext = {{24{ld_byte[7]}}, ld_byte};
            LBU:     load_ext = {24'h0, ld_byte};
            LH:      load_ext = {{16{ld_half[15]}}, ld_half};
            LHU:     load_ext = {16'h0, ld_half};
            LW:      load_ext = load_word;
            default: load_ext = '0;
        endcase
    end

    // Writeback source
    always_comb begin
        case (current_instr.w_sel)
            W_LOAD:  wdata = load_ext;
            W_PC4:   wdata = current_instr.pc4;
            W_IMM_U: wdata = current_instr.imm_u;
            W_ALU:   wdata = current_instr.port_out;
            default: wdata = '0;
        endcase
    end

    // Misalignment first, the bus was never used then
    always_comb begin
        if (misaligned) begin
            exc = current_instr.dren ? EXC_MAL_L : EXC_MAL_S;
        end else if (bus_error && is_mem) begin
            exc = current_instr.dren ? EXC_FAULT_L : EXC_FAULT_S;
        end else begin
            exc = EXC_NONE;
        end
    end

    always_comb begin
        mem_wb.valid     = current_instr.valid && !mem_stall;
        mem_wb.rd        = current_instr.rd;
        // No register update on a trapping access
        mem_wb.reg_write = current_instr.reg_write && (exc == EXC_NONE);
        mem_wb.reg_wdata = wdata;
        mem_wb.exc       = exc;
        // Raw address, not the word-aligned bus one
        mem_wb.badaddr   = (exc != EXC_NONE) ? current_instr.port_out : '0;
    end

endmodule

//--- hdl/load_store_controller.sv
`timescale 1ns/10ps

module load_store_controller (
    input  logic                    CLK,
    input  logic                    rst,
    input  mem_stage_pkg::ex_mem_t  ex_mem,
    input  mem_stage_pkg::access_t  access,
    input  mem_stage_pkg::axi_rsp_t axi_rsp,
    output mem_stage_pkg::ex_mem_t  current_instr,
    output mem_stage_pkg::axi_req_t axi_req,
    output logic                    mem_stall,
    output mem_stage_pkg::word_t    load_word,
    output logic                    bus_error
);

    import mem_stage_pkg::*;

    lsc_state_e state;
    lsc_state_e state_next;

    logic start;
    logic go;
    logic is_wr;
    logic is_rd;
    logic aw_done;
    logic w_done;
    logic aw_fire;
    logic w_fire;
    logic ar_fire;
    logic b_fire;
    logic r_fire;
    logic addr_ok;

    // Incoming record touches memory
    assign start = ex_mem.valid && (ex_mem.dren || ex_mem.dwen);

    // Held record really goes out on the bus
    assign go    = (access.rd_en || access.wr_en) && !access.misaligned;
    // Write wins if both enables are set, keeps channels exclusive
    assign is_wr = access.wr_en;
    assign is_rd = access.rd_en && !access.wr_en;

    // Master outputs, from registered state and held record only
    always_comb begin
        axi_req.aw_valid = (state == LSC_ADDR) && go && is_wr && !aw_done;
        axi_req.aw_addr  = access.addr;
        axi_req.w_valid  = (state == LSC_ADDR) && go && is_wr && !w_done;
        axi_req.w_data   = access.wdata;
        axi_req.w_strb   = access.strb;
        axi_req.b_ready  = (state == LSC_RESP) && is_wr;
        axi_req.ar_valid = (state == LSC_ADDR) && go && is_rd;
        axi_req.ar_addr  = access.addr;
        axi_req.r_ready  = (state == LSC_RESP) && is_rd;
    end

    // Handshakes
    assign aw_fire = axi_req.aw_valid && axi_rsp.aw_ready;
    assign w_fire  = axi_req.w_valid && axi_rsp.w_ready;
    assign ar_fire = axi_req.ar_valid && axi_rsp.ar_ready;
    assign b_fire  = axi_req.b_ready && axi_rsp.b_valid;
    assign r_fire  = axi_req.r_ready && axi_rsp.r_valid;

    // AW and W may complete in either order
    assign addr_ok = is_wr ? ((aw_done || aw_fire) && (w_done || w_fire)) : ar_fire;

    // Misaligned records sit in ADDR for one cycle without stalling
    assign mem_stall = ((state == LSC_ADDR) && go) || (state == LSC_RESP);

    always_comb begin
        state_next = state;
        case (state)
            LSC_IDLE: begin
                if (start) begin
                    state_next = LSC_ADDR;
                end
            end
            LSC_ADDR: begin
                if (!go) begin
                    // Nothing to send, behave like IDLE
                    state_next = start ? LSC_ADDR : LSC_IDLE;
                end else if (addr_ok) begin
                    state_next = LSC_RESP;
                end
            end
            LSC_RESP: begin
                if (b_fire || r_fire) begin
                    state_next = LSC_DONE;
                end
            end
            LSC_DONE: begin
                // Result visible this cycle, next record accepted on the edge
                state_next = start ? LSC_ADDR : LSC_IDLE;
            end
            default: state_next = LSC_IDLE;
        endcase
    end

    // State and instruction register
    always_ff @(posedge CLK) begin
        if (rst) begin
            state               <= LSC_IDLE;
            current_instr.valid <= 1'b0;
        end else begin
            state <= state_next;
            if (!mem_stall) begin
                current_instr <= ex_mem;
            end
        end
    end

    // Per-channel completion, cleared when leaving ADDR
    always_ff @(posedge CLK) begin
        if (rst || (state_next != LSC_ADDR)) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            aw_done <= aw_done || aw_fire;
            w_done  <= w_done || w_fire;
        end
    end

    // Read word
    always_ff @(posedge CLK) begin
        if (r_fire) begin
            load_word <= axi_rsp.r_data;
        end
    end

    // Response status of the last transaction
    always_ff @(posedge CLK) begin
        if (rst) begin
            bus_error <= 1'b0;
        end else if (b_fire) begin
            bus_error <= (axi_rsp.b_resp != AXI_RESP_OKAY);
        end else if (r_fire) begin
            bus_error <= (axi_rsp.r_resp != AXI_RESP_OKAY);
        end
    end

    // Never a read and a write address at once
    a_no_overlap: assert property (@(posedge CLK) disable iff (rst)
        !(axi_req.aw_valid && axi_req.ar_valid))
        else $error("aw_valid and ar_valid both high");

    // Valid held until the slave takes it
    a_aw_hold: assert property (@(posedge CLK) disable iff (rst)
        axi_req.aw_valid && !axi_rsp.aw_ready |=> axi_req.aw_valid)
        else $error("aw_valid dropped before aw_ready");

    a_ar_hold: assert property (@(posedge CLK) disable iff (rst)
        axi_req.ar_valid && !axi_rsp.ar_ready |=> axi_req.ar_valid)
        else $error("ar_valid dropped before ar_ready");

endmodule

//--- hdl/mem_access_decode.sv
`timescale 1ns/10ps

module mem_access_decode (
    input  mem_stage_pkg::ex_mem_t instr,
    output mem_stage_pkg::access_t access
);

    import mem_stage_pkg::*;

    logic [1:0] offset;
    logic       is_mem;
    logic       mal;
    strb_t      strb;
    word_t      wdata;

    // Byte position inside the word
    assign offset = instr.port_out[1:0];
    assign is_mem = instr.valid && (instr.dren || instr.dwen);

    // Lane strobes, little-endian
    always_comb begin
        case (instr.load_type)
            LB, LBU: strb = strb_t'(4'b0001 << offset);
            LH, LHU: strb = offset[1] ? 4'b1100 : 4'b0011;
            LW:      strb = 4'b1111;
            default: strb = 4'b0000;
        endcase
    end

    // Halves need an even offset, words a zero offset
    always_comb begin
        case (instr.load_type)
            LW:      mal = (offset != 2'b00);
            LH, LHU: mal = offset[0];
            default: mal = 1'b0;
        endcase
    end

    // Store data moved into its byte lanes
    always_comb begin
        case (instr.load_type)
            LB, LBU: wdata = word_t'({24'h0, instr.rs2_data[7:0]}) << {offset, 3'b000};
            LH, LHU: begin
                if (offset[1]) begin
                    wdata = {instr.rs2_data[15:0], 16'h0};
                end else begin
                    wdata = {16'h0, instr.rs2_data[15:0]};
                end
            end
            LW:      wdata = instr.rs2_data;
            default: wdata = '0;
        endcase
    end

    // Bubbles never request the bus
    always_comb begin
        access.rd_en      = instr.valid && instr.dren;
        access.wr_en      = instr.valid && instr.dwen;
        access.addr       = {instr.port_out[31:2], 2'b00};
        access.strb       = strb;
        access.wdata      = wdata;
        // Only meaningful for real memory records
        access.misaligned = is_mem && mal;
    end

    // Any aligned access must select at least one lane
    always_comb begin
        if (is_mem && !mal) begin
            assert final (strb != 4'b0000)
                else $error("aligned access with empty strobe, load_type %0d",
                            instr.load_type);
        end
    end

endmodule

//--- hdl/mem_stage_pkg.sv
package mem_stage_pkg;

    // Data and address word
    typedef logic [31:0] word_t;
    // One enable per byte lane
    typedef logic [3:0]  strb_t;
    // Register file index
    typedef logic [4:0]  reg_idx_t;
    // AXI response code
    typedef logic [1:0]  axi_resp_t;

    // Only OKAY counts as success
    localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

    // Access width and signedness, stores reuse LB/LH/LW
    typedef enum logic [2:0] {LB, LH, LW, LBU, LHU} load_type_e;

    // Writeback source
    typedef enum logic [1:0] {W_LOAD, W_PC4, W_IMM_U, W_ALU} w_sel_e;

    // Exception cause
    typedef enum logic [2:0] {
        EXC_NONE,
        EXC_MAL_L,
        EXC_MAL_S,
        EXC_FAULT_L,
        EXC_FAULT_S
    } exc_e;

    // Load/store controller FSM
    typedef enum logic [1:0] {LSC_IDLE, LSC_ADDR, LSC_RESP, LSC_DONE} lsc_state_e;

    // Record handed over by execute
    typedef struct packed {
        logic       valid;
        word_t      pc;
        word_t      pc4;
        logic       dren;
        logic       dwen;
        load_type_e load_type;
        word_t      rs2_data;   // store source
        word_t      port_out;   // ALU result or effective address
        word_t      imm_u;
        w_sel_e     w_sel;
        reg_idx_t   rd;
        logic       reg_write;
        logic       halt;
    } ex_mem_t;

    // Decoded data access
    typedef struct packed {
        logic  rd_en;
        logic  wr_en;
        word_t addr;        // word aligned
        strb_t strb;
        word_t wdata;       // already in its lanes
        logic  misaligned;
    } access_t;

    // Master driven AXI4-Lite
    typedef struct packed {
        logic  aw_valid;
        word_t aw_addr;
        logic  w_valid;
        word_t w_data;
        strb_t w_strb;
        logic  b_ready;
        logic  ar_valid;
        word_t ar_addr;
        logic  r_ready;
    } axi_req_t;

    // Slave driven AXI4-Lite
    typedef struct packed {
        logic      aw_ready;
        logic      w_ready;
        logic      b_valid;
        axi_resp_t b_resp;
        logic      ar_ready;
        logic      r_valid;
        word_t     r_data;
        axi_resp_t r_resp;
    } axi_rsp_t;

    // Record handed to writeback
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     reg_write;
        word_t    reg_wdata;
        exc_e     exc;
        word_t    badaddr;
    } mem_wb_t;

endpackage
